// ==== Bender.yml ====
package:
  name: color_detect

sources:
  - video_geom_pkg.sv
  - color_pkg.sv
  - patch_window.sv
  - rgb_accumulator.sv
  - color_classifier.sv
  - detect_sequencer.sv
  - color_detect_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - color_detect_tb.sv

// ==== color_classifier.sv ====
module color_classifier #(
    parameter int  patch_side_log2 = 3,
    localparam int sum_w           = 4 + 2 * patch_side_log2
) (
    input  logic [sum_w-1:0]       red_sum,
    input  logic [sum_w-1:0]       green_sum,
    input  logic [sum_w-1:0]       blue_sum,
    output color_pkg::color_code_t code
);

    import color_pkg::*;

    channel_t   avg_r, avg_g, avg_b;
    channel_t   max_c, min_c, sat;
    // zero-extended averages so +1 never wraps
    logic [4:0] r, g, b;
    logic [4:0] rg_diff;
    logic       is_red, is_yellow, is_blue;

    // divide by patch area
    assign avg_r = channel_t'(red_sum >> (2 * patch_side_log2));
    assign avg_g = channel_t'(green_sum >> (2 * patch_side_log2));
    assign avg_b = channel_t'(blue_sum >> (2 * patch_side_log2));

    assign r = {1'b0, avg_r};
    assign g = {1'b0, avg_g};
    assign b = {1'b0, avg_b};

    // brightness and saturation
    assign max_c = (avg_r >= avg_g && avg_r >= avg_b) ? avg_r :
                   (avg_g >= avg_b) ? avg_g : avg_b;
    assign min_c = (avg_r <= avg_g && avg_r <= avg_b) ? avg_r :
                   (avg_g <= avg_b) ? avg_g : avg_b;
    assign sat   = max_c - min_c;

    assign rg_diff = (r > g) ? (r - g) : (g - r);

    // a bright patch needs the dominant channel ahead by more than one step
    // a dark patch only needs the dominant channel to lead
    assign is_red = (sat > sat_th) &&
                    (((r > bright_th) && (r > g + 5'd1) && (r > b + 5'd1)) ||
                     ((max_c < dark_th) && (r > g) && (r > b)));

    assign is_yellow = (sat > sat_y_th) && (rg_diff < yellow_balance_th) &&
                       (((r > bright_th) && (g > bright_th) &&
                         (r > b + 5'd1) && (g > b + 5'd1)) ||
                        ((max_c < dark_th) && (r > b) && (g > b)));

    assign is_blue = (sat > sat_th) &&
                     (((b > bright_th) && (b > r + 5'd1) && (b > g + 5'd1)) ||
                      ((max_c < dark_th) && (b > r) && (b > g)));

    // red wins over yellow, yellow over blue
    always_comb begin
        if (is_red) begin
            code = code_red;
        end else if (is_yellow) begin
            code = code_yellow;
        end else if (is_blue) begin
            code = code_blue;
        end else begin
            code = code_none;
        end
    end

endmodule

// ==== color_detect.f ====
video_geom_pkg.sv
color_pkg.sv
patch_window.sv
rgb_accumulator.sv
color_classifier.sv
detect_sequencer.sv
color_detect_top.sv
tb_clock_gen.sv
color_detect_tb.sv

// ==== color_detect_tb.sv ====
module color_detect_tb;

    import video_geom_pkg::*;
    import color_pkg::*;

    localparam int patch_side  = 8;
    localparam int band_top    = 337;
    localparam int band_end    = band_top + patch_side;
    localparam int num_runs    = 30;
    localparam int cycle_limit = num_runs * 12 * 640 + num_runs * 64 + 500;

    // left column per level and slot
    localparam int left_col [4][4] = '{
        '{317, 0,   0,   0},
        '{207, 427, 0,   0},
        '{127, 317, 507, 0},
        '{89,  241, 393, 545}
    };

    logic          pclk;
    logic          reset;
    level_t        lvl;
    logic          countdown_done;
    logic          comparison_done;
    pixel_coord_t  x_pixel;
    pixel_coord_t  y_pixel;
    channel_t      red_port;
    channel_t      green_port;
    channel_t      blue_port;
    color_result_u detected_color;
    logic          color_done;

    logic [31:0]   rng_state = 32'h4fa586b8;
    int            cycle = 0;
    int            exp_done_cycle = -1;
    int            run_level = 0;
    logic          scanning = 1'b0;
    logic          done_seen = 1'b0;
    color_result_u done_result;

    tb_clock_gen clock_gen_inst (
        .pclk  (pclk),
        .reset (reset)
    );

    color_detect_top #(
        .patch_side_log2 (3)
    ) color_detect_top_inst (
        .pclk            (pclk),
        .reset           (reset),
        .lvl             (lvl),
        .countdown_done  (countdown_done),
        .comparison_done (comparison_done),
        .x_pixel         (x_pixel),
        .y_pixel         (y_pixel),
        .red_port        (red_port),
        .green_port      (green_port),
        .blue_port       (blue_port),
        .detected_color  (detected_color),
        .color_done      (color_done)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // target value plus noise of -1..+1 clamped to 0..15
    function automatic channel_t add_noise(input int base);
        int v;
        v = base + int'(next_rand() % 3) - 1;
        if (v < 0) begin
            v = 0;
        end else if (v > 15) begin
            v = 15;
        end
        return channel_t'(v);
    endfunction

    // slot of the patch that holds (x, y) or -1 outside all patches
    function automatic int patch_at(input int lv, input int x, input int y);
        int hit;
        hit = -1;
        if (y >= band_top && y < band_end) begin
            for (int k = 0; k <= lv; k++) begin
                if (x >= left_col[lv][k] && x < left_col[lv][k] + patch_side) begin
                    hit = k;
                end
            end
        end
        return hit;
    endfunction

    // reference color rules on 8x8 averages
    function automatic color_code_t classify_sums(input int rs, input int gs, input int bs);
        int r, g, b, mx, mn, sat, rg;
        r = rs >> 6;
        g = gs >> 6;
        b = bs >> 6;
        mx = (r > g) ? r : g;
        mx = (b > mx) ? b : mx;
        mn = (r < g) ? r : g;
        mn = (b < mn) ? b : mn;
        sat = mx - mn;
        rg = (r > g) ? r - g : g - r;
        if (sat > 2 && ((r > 8 && r > g + 1 && r > b + 1) || (mx < 8 && r > g && r > b))) begin
            return 2'b01;
        end
        if (sat > 1 && rg < 4 && ((r > 8 && g > 8 && r > b + 1 && g > b + 1) ||
                                  (mx < 8 && r > b && g > b))) begin
            return 2'b10;
        end
        if (sat > 2 && ((b > 8 && b > r + 1 && b > g + 1) || (mx < 8 && b > r && b > g))) begin
            return 2'b11;
        end
        return 2'b00;
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_result(input color_result_u got, input color_result_u exp);
        for (int k = 0; k < 4; k++) begin
            if (got.slot[k] !== exp.slot[k]) begin
                $display("[ERROR] %0t detected_color slot %0d got %b expected %b (raw %h vs %h)",
                         $time, k, got.slot[k], exp.slot[k], got.raw, exp.raw);
                abort_run();
            end
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t color_done got %b expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    // random pixels anywhere while the result must hold at exp
    task automatic idle_cycles(input int n, input color_result_u exp);
        for (int i = 0; i < n; i++) begin
            @(posedge pclk);
            x_pixel    <= pixel_coord_t'(next_rand() % 640);
            y_pixel    <= pixel_coord_t'(next_rand() % 480);
            red_port   <= channel_t'(next_rand());
            green_port <= channel_t'(next_rand());
            blue_port  <= channel_t'(next_rand());
            @(negedge pclk);
            check_result(detected_color, exp);
        end
    endtask

    task automatic do_run(input int lv);
        int            base_r [4];
        int            base_g [4];
        int            base_b [4];
        int            sum_r [4];
        int            sum_g [4];
        int            sum_b [4];
        int            k;
        int            kind;
        channel_t      r, g, b;
        color_result_u exp;
        // target per patch is red, yellow, blue, gray or random
        for (int s = 0; s < 4; s++) begin
            kind = int'(next_rand() % 5);
            case (kind)
                0: begin
                    base_r[s] = 13;
                    base_g[s] = 2;
                    base_b[s] = 3;
                end
                1: begin
                    base_r[s] = 12;
                    base_g[s] = 11;
                    base_b[s] = 2;
                end
                2: begin
                    base_r[s] = 2;
                    base_g[s] = 3;
                    base_b[s] = 13;
                end
                3: begin
                    base_r[s] = 7;
                    base_g[s] = 7;
                    base_b[s] = 7;
                end
                default: begin
                    base_r[s] = int'(next_rand() % 16);
                    base_g[s] = int'(next_rand() % 16);
                    base_b[s] = int'(next_rand() % 16);
                end
            endcase
            sum_r[s] = 0;
            sum_g[s] = 0;
            sum_b[s] = 0;
        end
        @(posedge pclk);
        lvl            <= level_t'(lv);
        countdown_done <= 1'b1;
        run_level = lv;
        done_seen = 1'b0;
        @(posedge pclk);
        countdown_done <= 1'b0;
        scanning = 1'b1;
        // one row before the band, the band, and two rows after it
        for (int y = band_top - 1; y <= band_end + 1; y++) begin
            for (int x = 0; x < 640; x++) begin
                k = patch_at(lv, x, y);
                if (k >= 0) begin
                    r = add_noise(base_r[k]);
                    g = add_noise(base_g[k]);
                    b = add_noise(base_b[k]);
                    sum_r[k] += int'(r);
                    sum_g[k] += int'(g);
                    sum_b[k] += int'(b);
                end else begin
                    r = channel_t'(next_rand());
                    g = channel_t'(next_rand());
                    b = channel_t'(next_rand());
                end
                @(posedge pclk);
                x_pixel    <= pixel_coord_t'(x);
                y_pixel    <= pixel_coord_t'(y);
                red_port   <= r;
                green_port <= g;
                blue_port  <= b;
            end
        end
        scanning = 1'b0;
        while (!done_seen) begin
            @(posedge pclk);
        end
        exp.raw = 8'h00;
        for (int s = 0; s <= lv; s++) begin
            exp.slot[s] = classify_sums(sum_r[s], sum_g[s], sum_b[s]);
        end
        check_result(done_result, exp);
        idle_cycles(1 + int'(next_rand() % 16), exp);
        @(posedge pclk);
        comparison_done <= 1'b1;
        @(posedge pclk);
        comparison_done <= 1'b0;
        idle_cycles(8, '0);
    endtask

    // done pulse timing, timeout and capture of the result at done
    always @(negedge pclk) begin
        cycle = cycle + 1;
        if (cycle > cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            abort_run();
        end else begin
            if (scanning && y_pixel == pixel_coord_t'(band_end) && x_pixel == '0) begin
                exp_done_cycle = cycle + run_level + 2;
            end
            check_done(color_done, cycle == exp_done_cycle);
            if (color_done) begin
                done_seen   = 1'b1;
                done_result = detected_color;
            end
        end
    end

    initial begin
        int lv;
        int prev;
        lvl             = '0;
        countdown_done  = 1'b0;
        comparison_done = 1'b0;
        x_pixel         = '0;
        y_pixel         = '0;
        red_port        = '0;
        green_port      = '0;
        blue_port       = '0;
        while (reset !== 1'b0) begin
            @(posedge pclk);
        end
        // nothing may happen without countdown_done
        idle_cycles(50, '0);
        for (int i = 0; i < 10; i++) begin
            do_run(0);
        end
        for (int l = 1; l < 4; l++) begin
            for (int i = 0; i < 4; i++) begin
                do_run(l);
            end
        end
        // back-to-back runs where the level changes every run
        prev = 0;
        for (int i = 0; i < 8; i++) begin
            lv = (prev + 1 + int'(next_rand() % 3)) % 4;
            do_run(lv);
            prev = lv;
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== color_detect_top.sv ====
module color_detect_top #(
    parameter int patch_side_log2 = 3
) (
    input  logic                         pclk,
    input  logic                         reset,
    input  video_geom_pkg::level_t       lvl,
    input  logic                         countdown_done,
    input  logic                         comparison_done,
    input  video_geom_pkg::pixel_coord_t x_pixel,
    input  video_geom_pkg::pixel_coord_t y_pixel,
    input  color_pkg::channel_t          red_port,
    input  color_pkg::channel_t          green_port,
    input  color_pkg::channel_t          blue_port,
    output color_pkg::color_result_u     detected_color,
    output logic                         color_done
);

    import video_geom_pkg::*;
    import color_pkg::*;

    localparam int sum_w = 4 + 2 * patch_side_log2;

    level_t            level;
    slot_t             hit_slot;
    slot_t             read_slot;
    logic              in_patch;
    logic              arm;
    logic              band_passed;
    logic              clear_sums;
    logic              add_pixel;
    logic [sum_w-1:0]  red_sum;
    logic [sum_w-1:0]  green_sum;
    logic [sum_w-1:0]  blue_sum;
    color_code_t       code;

    patch_window #(
        .patch_side_log2 (patch_side_log2)
    ) patch_window_inst (
        .level       (level),
        .x_pixel     (x_pixel),
        .y_pixel     (y_pixel),
        .in_patch    (in_patch),
        .hit_slot    (hit_slot),
        .arm         (arm),
        .band_passed (band_passed)
    );

    rgb_accumulator #(
        .patch_side_log2 (patch_side_log2)
    ) rgb_accumulator_inst (
        .pclk       (pclk),
        .reset      (reset),
        .clear_sums (clear_sums),
        .add_pixel  (add_pixel),
        .hit_slot   (hit_slot),
        .read_slot  (read_slot),
        .red_port   (red_port),
        .green_port (green_port),
        .blue_port  (blue_port),
        .red_sum    (red_sum),
        .green_sum  (green_sum),
        .blue_sum   (blue_sum)
    );

    // classifies whichever slot the sequencer is reading
    color_classifier #(
        .patch_side_log2 (patch_side_log2)
    ) color_classifier_inst (
        .red_sum   (red_sum),
        .green_sum (green_sum),
        .blue_sum  (blue_sum),
        .code      (code)
    );

    detect_sequencer detect_sequencer_inst (
        .pclk            (pclk),
        .reset           (reset),
        .lvl             (lvl),
        .countdown_done  (countdown_done),
        .comparison_done (comparison_done),
        .arm             (arm),
        .band_passed     (band_passed),
        .in_patch        (in_patch),
        .code            (code),
        .level           (level),
        .clear_sums      (clear_sums),
        .add_pixel       (add_pixel),
        .read_slot       (read_slot),
        .detected_color  (detected_color),
        .color_done      (color_done)
    );

endmodule

// ==== color_pkg.sv ====
package color_pkg;

    // one 4-bit color channel or one channel average
    typedef logic [3:0] channel_t;

    // per-patch color code
    typedef logic [1:0] color_code_t;

    localparam color_code_t code_none   = 2'b00;
    localparam color_code_t code_red    = 2'b01;
    localparam color_code_t code_yellow = 2'b10;
    localparam color_code_t code_blue   = 2'b11;

    // classification thresholds on the averaged channels
    localparam int bright_th = 8;
    localparam int dark_th   = 8;
    localparam int sat_th    = 2;
    // yellow accepts a weaker saturation
    localparam int sat_y_th  = 1;

    // |r - g| must stay below this for yellow
    localparam int yellow_balance_th = 4;

    // detection result
    // the sequencer shifts the raw view
    // the slot view gives code k at bits 2k+1:2k
    typedef union packed {
        logic [7:0]             raw;
        color_code_t [3:0]      slot;
    } color_result_u;

endpackage

// ==== detect_sequencer.sv ====
module detect_sequencer (
    input  logic                     pclk,
    input  logic                     reset,
    input  video_geom_pkg::level_t   lvl,
    input  logic                     countdown_done,
    input  logic                     comparison_done,
    input  logic                     arm,
    input  logic                     band_passed,
    input  logic                     in_patch,
    input  color_pkg::color_code_t   code,
    output video_geom_pkg::level_t   level,
    output logic                     clear_sums,
    output logic                     add_pixel,
    output video_geom_pkg::slot_t    read_slot,
    output color_pkg::color_result_u detected_color,
    output logic                     color_done
);

    import video_geom_pkg::*;
    import color_pkg::*;

    localparam logic [2:0] st_idle         = 3'd0;
    localparam logic [2:0] st_arm_wait     = 3'd1;
    localparam logic [2:0] st_accumulate   = 3'd2;
    localparam logic [2:0] st_classify     = 3'd3;
    localparam logic [2:0] st_wait_compare = 3'd4;

    logic [2:0] state;
    logic       last_slot;

    // slot 0 is classified last
    assign last_slot = (read_slot == '0);

    assign clear_sums = (state == st_arm_wait);
    assign add_pixel  = (state == st_accumulate) && in_patch;

    always_ff @(posedge pclk, posedge reset) begin
        if (reset) begin
            state          <= st_idle;
            level          <= '0;
            read_slot      <= '0;
            detected_color <= '0;
            color_done     <= 1'b0;
        end else begin
            color_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (countdown_done) begin
                        level <= lvl;
                        state <= st_arm_wait;
                    end
                end
                st_arm_wait: begin
                    detected_color <= '0;
                    if (arm) begin
                        state <= st_accumulate;
                    end
                end
                st_accumulate: begin
                    // highest slot goes first so slot 0 lands in the low bits
                    if (band_passed) begin
                        read_slot <= slot_t'(level);
                        state     <= st_classify;
                    end
                end
                st_classify: begin
                    detected_color.raw <= {detected_color.raw[5:0], code};
                    if (last_slot) begin
                        color_done <= 1'b1;
                        state      <= st_wait_compare;
                    end else begin
                        read_slot <= read_slot - 1'b1;
                    end
                end
                st_wait_compare: begin
                    // hold the result until the game logic has used it
                    if (comparison_done) begin
                        detected_color <= '0;
                        state          <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// ==== patch_window.sv ====
module patch_window #(
    parameter int patch_side_log2 = 3
) (
    input  video_geom_pkg::level_t       level,
    input  video_geom_pkg::pixel_coord_t x_pixel,
    input  video_geom_pkg::pixel_coord_t y_pixel,
    output logic                         in_patch,
    output video_geom_pkg::slot_t        hit_slot,
    output logic                         arm,
    output logic                         band_passed
);

    import video_geom_pkg::*;

    localparam int patch_side = 1 << patch_side_log2;

    logic in_band;

    // band rows are band_top_row .. band_top_row + side - 1
    assign in_band = (int'(y_pixel) >= int'(band_top_row)) &&
                     (int'(y_pixel) < int'(band_top_row) + patch_side);

    // scan only the windows that exist at this level
    always_comb begin
        in_patch = 1'b0;
        hit_slot = '0;
        for (int k = 0; k < max_patches; k++) begin
            if (in_band && (k <= int'(level)) &&
                (int'(x_pixel) >= int'(patch_left_col[level][k])) &&
                (int'(x_pixel) < int'(patch_left_col[level][k]) + patch_side)) begin
                in_patch = 1'b1;
                hit_slot = slot_t'(k);
            end
        end
    end

    // band starts at column 0 of the top row
    assign arm = (y_pixel == band_top_row) && (x_pixel == '0);

    // first row below the band and everything after it
    assign band_passed = int'(y_pixel) >= int'(band_top_row) + patch_side;

endmodule

// ==== rgb_accumulator.sv ====
module rgb_accumulator #(
    parameter int  patch_side_log2 = 3,
    localparam int sum_w           = 4 + 2 * patch_side_log2
) (
    input  logic                    pclk,
    input  logic                    reset,
    input  logic                    clear_sums,
    input  logic                    add_pixel,
    input  video_geom_pkg::slot_t   hit_slot,
    input  video_geom_pkg::slot_t   read_slot,
    input  color_pkg::channel_t     red_port,
    input  color_pkg::channel_t     green_port,
    input  color_pkg::channel_t     blue_port,
    output logic [sum_w-1:0]        red_sum,
    output logic [sum_w-1:0]        green_sum,
    output logic [sum_w-1:0]        blue_sum
);

    import video_geom_pkg::*;
    import color_pkg::*;

    // channel index 0 = red, 1 = green, 2 = blue
    channel_t [2:0]           pix;
    logic [2:0][sum_w-1:0]    acc [max_patches];

    assign pix = {blue_port, green_port, red_port};

    always_ff @(posedge pclk, posedge reset) begin
        if (reset) begin
            for (int s = 0; s < max_patches; s++) begin
                acc[s] <= '0;
            end
        end else if (clear_sums) begin
            for (int s = 0; s < max_patches; s++) begin
                acc[s] <= '0;
            end
        end else if (add_pixel) begin
            // one pixel per cycle into the hit patch
            for (int c = 0; c < 3; c++) begin
                acc[hit_slot][c] <= acc[hit_slot][c] + sum_w'(pix[c]);
            end
        end
    end

    // slot read-out for the classifier
    assign red_sum   = acc[read_slot][0];
    assign green_sum = acc[read_slot][1];
    assign blue_sum  = acc[read_slot][2];

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 16
) (
    output logic pclk,
    output logic reset
);

    initial begin
        pclk = 1'b0;
        forever #half_period pclk = ~pclk;
    end

    // reset drops on a rising edge after reset_cycles edges
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge pclk);
        reset <= 1'b0;
    end

endmodule

// ==== video_geom_pkg.sv ====
package video_geom_pkg;

    // one screen coordinate in x or y
    typedef logic [9:0] pixel_coord_t;

    // game level 0..3 that also gives the patch count minus one
    typedef logic [1:0] level_t;

    // patch index inside the band
    typedef logic [1:0] slot_t;

    localparam int max_patches = 4;

    // all patches share this first row
    localparam pixel_coord_t band_top_row = 10'd337;

    // left column of each patch indexed by [level][slot]
    // entries past the level's patch count are never hit
    localparam pixel_coord_t patch_left_col [max_patches][max_patches] = '{
        '{10'd317, 10'd0,   10'd0,   10'd0},
        '{10'd207, 10'd427, 10'd0,   10'd0},
        '{10'd127, 10'd317, 10'd507, 10'd0},
        '{10'd89,  10'd241, 10'd393, 10'd545}
    };

endpackage
